// File: src/memCtrlPkg.sv
`default_nettype none

package memCtrlPkg;

    // bus widths
    localparam int addrWidth    = 32;
    localparam int wordWidth    = 32;
    localparam int byteWidth    = 8;
    localparam int bytesPerWord = 4;

    // stage counter runs 0..4
    localparam int stageWidth = 3;
    localparam int lenWidth   = 3;

    localparam int opWidth    = 2;
    localparam int ownerWidth = 2;

    // transfer in progress
    localparam logic [opWidth-1:0] opFetch = 2'd0;
    localparam logic [opWidth-1:0] opLoad  = 2'd1;
    localparam logic [opWidth-1:0] opStore = 2'd2;

    // data is 01, fetch is 10
    localparam logic [ownerWidth-1:0] ownerNone  = 2'b00;
    localparam logic [ownerWidth-1:0] ownerData  = 2'b01;
    localparam logic [ownerWidth-1:0] ownerFetch = 2'b10;

    // RAM write strobe values
    localparam logic memRead  = 1'b0;
    localparam logic memWrite = 1'b1;

    // arbiter states
    localparam logic [1:0] arbIdle = 2'd0;
    localparam logic [1:0] arbBusy = 2'd1;
    localparam logic [1:0] arbTail = 2'd2;

    // filled one byte lane at a time, handed out as a word
    typedef union packed {
        logic [wordWidth-1:0]                    word;
        logic [bytesPerWord-1:0][byteWidth-1:0] bytes;
    } memWord_u;

endpackage

`default_nettype wire

// File: src/memArbiter.sv
`timescale 1ns/1ps
`default_nettype none

module memArbiter (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              ready,
    input  logic                              ioFull,
    input  logic                              fetchEn,
    input  logic                              dataEn,
    input  logic                              dataStore,
    input  logic                              finish,
    output logic                              start,
    output logic [memCtrlPkg::opWidth-1:0]    op,
    output logic [memCtrlPkg::ownerWidth-1:0] owner
);

    logic                              active;
    logic                              idle;
    logic [1:0]                        state;
    logic [memCtrlPkg::opWidth-1:0]    opReg;
    logic [memCtrlPkg::opWidth-1:0]    nextOp;
    logic [memCtrlPkg::ownerWidth-1:0] ownerReg;
    logic [memCtrlPkg::ownerWidth-1:0] nextOwner;

    assign active = ready && !ioFull;
    assign idle   = (state == memCtrlPkg::arbIdle);
    assign start  = active && idle && (fetchEn || dataEn);

    // data side beats fetch
    always_comb begin
        if (dataEn) begin
            nextOwner = memCtrlPkg::ownerData;
            nextOp    = dataStore ? memCtrlPkg::opStore : memCtrlPkg::opLoad;
        end else begin
            nextOwner = memCtrlPkg::ownerFetch;
            nextOp    = memCtrlPkg::opFetch;
        end
    end

    // grant is visible in the start cycle itself
    assign op    = idle ? nextOp : opReg;
    assign owner = idle ? (start ? nextOwner : memCtrlPkg::ownerNone) : ownerReg;

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= memCtrlPkg::arbIdle;
            opReg    <= memCtrlPkg::opFetch;
            ownerReg <= memCtrlPkg::ownerNone;
        end else if (active) begin
            case (state)
                memCtrlPkg::arbIdle: begin
                    if (start) begin
                        opReg    <= nextOp;
                        ownerReg <= nextOwner;
                        // one-byte store finishes in its start cycle
                        state    <= finish ? memCtrlPkg::arbTail : memCtrlPkg::arbBusy;
                    end
                end
                memCtrlPkg::arbBusy: begin
                    if (finish) begin
                        state <= memCtrlPkg::arbTail;
                    end
                end
                // done cycle, requester still holds its enable
                memCtrlPkg::arbTail: begin
                    state    <= memCtrlPkg::arbIdle;
                    ownerReg <= memCtrlPkg::ownerNone;
                end
                default: begin
                    state <= memCtrlPkg::arbIdle;
                end
            endcase
        end
    end

    // no second grant until the sequencer closes the current transfer
    startLocked: assert property (@(posedge clk) disable iff (rst)
        start && !finish |=> !start until finish);

endmodule

`default_nettype wire

// File: src/byteSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module byteSequencer (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             ready,
    input  logic                             ioFull,
    input  logic                             start,
    input  logic [memCtrlPkg::opWidth-1:0]   op,
    input  logic [memCtrlPkg::addrWidth-1:0] fetchAddr,
    input  logic [memCtrlPkg::addrWidth-1:0] dataAddr,
    input  logic [memCtrlPkg::lenWidth-1:0]  dataLen,
    input  logic [memCtrlPkg::wordWidth-1:0] dataWrite,
    output logic [memCtrlPkg::addrWidth-1:0] memAddr,
    output logic                             memWe,
    output logic [memCtrlPkg::byteWidth-1:0] memWdata,
    output logic                             finish,
    output logic [memCtrlPkg::stageWidth-1:0] capture
);

    logic                              active;
    logic                              running;
    logic                              storing;
    logic [memCtrlPkg::stageWidth-1:0] stage;
    logic [memCtrlPkg::stageWidth-1:0] lastStage;
    logic [memCtrlPkg::addrWidth-1:0]  baseReg;
    logic [memCtrlPkg::addrWidth-1:0]  baseSel;
    logic [memCtrlPkg::addrWidth-1:0]  base;

    assign active = ready && !ioFull;

    // stage stays zero between transfers
    assign running = start || (stage != '0);
    assign storing = running && (op == memCtrlPkg::opStore);

    assign baseSel = (op == memCtrlPkg::opFetch) ? fetchAddr : dataAddr;
    assign base    = start ? baseSel : baseReg;
    assign memAddr = base + memCtrlPkg::addrWidth'(stage);

    // loads end one stage after their last read, stores on their last write
    always_comb begin
        case (op)
            memCtrlPkg::opFetch: lastStage = memCtrlPkg::stageWidth'(memCtrlPkg::bytesPerWord);
            memCtrlPkg::opStore: lastStage = dataLen - 3'd1;
            default:             lastStage = dataLen;
        endcase
    end

    assign finish = active && running && (stage == lastStage);

    // read data lags its address by one cycle, 3'b111 means nothing arriving
    assign capture = stage - 3'd1;

    assign memWe    = storing ? memCtrlPkg::memWrite : memCtrlPkg::memRead;
    assign memWdata = storing ?
        dataWrite[stage[1:0] * memCtrlPkg::byteWidth +: memCtrlPkg::byteWidth] : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            stage   <= '0;
            baseReg <= '0;
        end else if (active) begin
            if (finish) begin
                stage <= '0;
            end else if (running) begin
                stage <= stage + 3'd1;
            end
            if (start) begin
                baseReg <= baseSel;
            end
        end
    end

    // length 3 is not supported
    dataLenLegal: assert property (@(posedge clk) disable iff (rst)
        start && (op != memCtrlPkg::opFetch) |-> dataLen inside {3'd1, 3'd2, 3'd4});

endmodule

`default_nettype wire

// File: src/responseAssembler.sv
`timescale 1ns/1ps
`default_nettype none

module responseAssembler (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              ready,
    input  logic                              ioFull,
    input  logic [memCtrlPkg::opWidth-1:0]    op,
    input  logic [memCtrlPkg::stageWidth-1:0] capture,
    input  logic                              finish,
    input  logic [memCtrlPkg::byteWidth-1:0]  memRdata,
    output logic                              fetchDone,
    output logic [memCtrlPkg::wordWidth-1:0]  fetchInst,
    output logic                              dataDone,
    output logic [memCtrlPkg::wordWidth-1:0]  dataRead
);

    logic                 active;
    memCtrlPkg::memWord_u word;
    memCtrlPkg::memWord_u nextWord;

    assign active = ready && !ioFull;

    // first byte clears the rest, so short loads come out zero-extended
    always_comb begin
        nextWord = word;
        if (op != memCtrlPkg::opStore && capture < memCtrlPkg::bytesPerWord) begin
            if (capture == '0) begin
                nextWord.word = '0;
            end
            nextWord.bytes[capture[1:0]] = memRdata;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            fetchDone <= 1'b0;
            dataDone  <= 1'b0;
        end else if (active) begin
            fetchDone <= finish && (op == memCtrlPkg::opFetch);
            dataDone  <= finish && (op != memCtrlPkg::opFetch);
        end
    end

    // last byte arrives in the finish cycle so it comes from nextWord
    always_ff @(posedge clk) begin
        if (active) begin
            word <= nextWord;
            if (finish && op == memCtrlPkg::opFetch) begin
                fetchInst <= nextWord.word;
            end
            if (finish && op == memCtrlPkg::opLoad) begin
                dataRead <= nextWord.word;
            end
        end
    end

    // each done pulse lasts a single active cycle
    donePulse: assert property (@(posedge clk) disable iff (rst)
        (fetchDone || dataDone) && active |=> !fetchDone && !dataDone);

endmodule

`default_nettype wire

// File: src/memCtrl.sv
`timescale 1ns/1ps
`default_nettype none

module memCtrl (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              ready,
    input  logic                              ioFull,

    // instruction fetch
    input  logic                              fetchEn,
    input  logic [memCtrlPkg::addrWidth-1:0]  fetchAddr,
    output logic                              fetchDone,
    output logic [memCtrlPkg::wordWidth-1:0]  fetchInst,

    // data cache
    input  logic                              dataEn,
    input  logic                              dataStore,
    input  logic [memCtrlPkg::lenWidth-1:0]   dataLen,
    input  logic [memCtrlPkg::wordWidth-1:0]  dataWrite,
    input  logic [memCtrlPkg::addrWidth-1:0]  dataAddr,
    output logic                              dataDone,
    output logic [memCtrlPkg::wordWidth-1:0]  dataRead,

    // byte RAM
    input  logic [memCtrlPkg::byteWidth-1:0]  memRdata,
    output logic [memCtrlPkg::addrWidth-1:0]  memAddr,
    output logic                              memWe,
    output logic [memCtrlPkg::byteWidth-1:0]  memWdata,

    output logic [memCtrlPkg::ownerWidth-1:0] owner
);

    logic                              start;
    logic                              finish;
    logic [memCtrlPkg::opWidth-1:0]    op;
    logic [memCtrlPkg::stageWidth-1:0] capture;

    memArbiter arbiter (
        .clk       (clk),
        .rst       (rst),
        .ready     (ready),
        .ioFull    (ioFull),
        .fetchEn   (fetchEn),
        .dataEn    (dataEn),
        .dataStore (dataStore),
        .finish    (finish),
        .start     (start),
        .op        (op),
        .owner     (owner)
    );

    byteSequencer sequencer (
        .clk       (clk),
        .rst       (rst),
        .ready     (ready),
        .ioFull    (ioFull),
        .start     (start),
        .op        (op),
        .fetchAddr (fetchAddr),
        .dataAddr  (dataAddr),
        .dataLen   (dataLen),
        .dataWrite (dataWrite),
        .memAddr   (memAddr),
        .memWe     (memWe),
        .memWdata  (memWdata),
        .finish    (finish),
        .capture   (capture)
    );

    // returned bytes and done pulses
    responseAssembler assembler (
        .clk       (clk),
        .rst       (rst),
        .ready     (ready),
        .ioFull    (ioFull),
        .op        (op),
        .capture   (capture),
        .finish    (finish),
        .memRdata  (memRdata),
        .fetchDone (fetchDone),
        .fetchInst (fetchInst),
        .dataDone  (dataDone),
        .dataRead  (dataRead)
    );

endmodule

`default_nettype wire

// File: tb/clockGen.sv
`timescale 1ns/1ps
`default_nettype none

module clockGen (
    output logic clk,
    output logic rst
);

    localparam realtime halfPeriod = 50ns;
    localparam int resetCycles = 4;

    initial begin
        clk = 1'b0;
        forever #(halfPeriod) clk = ~clk;
    end

    // released on a falling edge, after four rising edges
    initial begin
        rst = 1'b1;
        #(2 * halfPeriod * resetCycles);
        rst = 1'b0;
    end

endmodule

`default_nettype wire

// File: tb/ramModel.sv
`timescale 1ns/1ps
`default_nettype none

module ramModel (
    input  logic                             clk,
    input  logic                             en,
    input  logic [memCtrlPkg::addrWidth-1:0] addr,
    input  logic                             we,
    input  logic [memCtrlPkg::byteWidth-1:0] wdata,
    output logic [memCtrlPkg::byteWidth-1:0] rdata
);

    localparam int depth = 256;

    logic [memCtrlPkg::byteWidth-1:0] mem [depth];

    // every bit of the index takes part in the pattern
    function automatic logic [7:0] fillByte(input int idx);
        logic [7:0] lo;
        lo = 8'(idx);
        return (lo * 8'd37 + 8'd11) ^ {lo[2:0], lo[7:3]};
    endfunction

    initial begin
        for (int i = 0; i < depth; i++) begin
            mem[i] = fillByte(i);
        end
        rdata = '0;
    end

    // held while the controller is stalled, so the byte in flight survives
    always @(posedge clk) begin
        if (en) begin
            if (we == memCtrlPkg::memWrite) begin
                mem[addr[7:0]] <= wdata;
            end
            rdata <= mem[addr[7:0]];
        end
    end

endmodule

`default_nettype wire

// File: tb/tbMemCtrl.sv
`timescale 1ns/1ps
`default_nettype none

module tbMemCtrl;

    localparam int timeoutCycles = 200;
    localparam int refDepth = 256;

    logic                              clk;
    logic                              rst;
    logic                              ready;
    logic                              ioFull;
    logic                              fetchEn;
    logic [memCtrlPkg::addrWidth-1:0]  fetchAddr;
    logic                              fetchDone;
    logic [memCtrlPkg::wordWidth-1:0]  fetchInst;
    logic                              dataEn;
    logic                              dataStore;
    logic [memCtrlPkg::lenWidth-1:0]   dataLen;
    logic [memCtrlPkg::wordWidth-1:0]  dataWrite;
    logic [memCtrlPkg::addrWidth-1:0]  dataAddr;
    logic                              dataDone;
    logic [memCtrlPkg::wordWidth-1:0]  dataRead;
    logic [memCtrlPkg::byteWidth-1:0]  memRdata;
    logic [memCtrlPkg::addrWidth-1:0]  memAddr;
    logic                              memWe;
    logic [memCtrlPkg::byteWidth-1:0]  memWdata;
    logic [memCtrlPkg::ownerWidth-1:0] owner;

    logic        active;
    logic        idlePhase;
    logic        simulPending;
    logic        expStore;
    logic [31:0] expInst;
    logic [31:0] expData;
    int          expDataLat;
    int          fetchCnt;
    int          dataCnt;
    int          errorCount;
    int          timeoutCount;
    logic [31:0] lcgState;
    logic [7:0]  refMem [refDepth];

    assign active = ready && !ioFull;

    clockGen clockGen (
        .clk (clk),
        .rst (rst)
    );

    memCtrl DUT (
        .clk       (clk),
        .rst       (rst),
        .ready     (ready),
        .ioFull    (ioFull),
        .fetchEn   (fetchEn),
        .fetchAddr (fetchAddr),
        .fetchDone (fetchDone),
        .fetchInst (fetchInst),
        .dataEn    (dataEn),
        .dataStore (dataStore),
        .dataLen   (dataLen),
        .dataWrite (dataWrite),
        .dataAddr  (dataAddr),
        .dataDone  (dataDone),
        .dataRead  (dataRead),
        .memRdata  (memRdata),
        .memAddr   (memAddr),
        .memWe     (memWe),
        .memWdata  (memWdata),
        .owner     (owner)
    );

    ramModel ram (
        .clk   (clk),
        .en    (active),
        .addr  (memAddr),
        .we    (memWe),
        .wdata (memWdata),
        .rdata (memRdata)
    );

    // active cycles each side has held the RAM since its last done pulse
    always_ff @(posedge clk) begin
        if (rst || owner != memCtrlPkg::ownerFetch || (fetchDone && active)) begin
            fetchCnt <= 0;
        end else if (active) begin
            fetchCnt <= fetchCnt + 1;
        end
        if (rst || owner != memCtrlPkg::ownerData || (dataDone && active)) begin
            dataCnt <= 0;
        end else if (active) begin
            dataCnt <= dataCnt + 1;
        end
    end

    idleAfterReset: assert property (@(posedge clk) disable iff (rst)
        idlePhase |-> !fetchDone && !dataDone && owner == memCtrlPkg::ownerNone
            && memWe == memCtrlPkg::memRead && memWdata == '0)
        else begin
            errorCount++;
            $display("Fail idleAfterReset expected %b actual %b",
                {2'b00, memCtrlPkg::ownerNone, memCtrlPkg::memRead, 8'h00},
                $sampled({fetchDone, dataDone, owner, memWe, memWdata}));
        end

    fetchValue: assert property (@(posedge clk) disable iff (rst)
        fetchDone |-> fetchInst == expInst)
        else begin
            errorCount++;
            $display("Fail fetch expected %h actual %h", $sampled(expInst),
                $sampled(fetchInst));
        end

    fetchLatency: assert property (@(posedge clk) disable iff (rst)
        fetchDone |-> fetchCnt == 5)
        else begin
            errorCount++;
            $display("Fail fetchLatency expected %0d actual %0d", 5, $sampled(fetchCnt));
        end

    loadValue: assert property (@(posedge clk) disable iff (rst)
        dataDone && !expStore |-> dataRead == expData)
        else begin
            errorCount++;
            $display("Fail load expected %h actual %h", $sampled(expData),
                $sampled(dataRead));
        end

    dataLatency: assert property (@(posedge clk) disable iff (rst)
        dataDone |-> dataCnt == expDataLat)
        else begin
            errorCount++;
            $display("Fail dataLatency expected %0d actual %0d", $sampled(expDataLat),
                $sampled(dataCnt));
        end

    dataWins: assert property (@(posedge clk) disable iff (rst)
        simulPending && active |-> owner == memCtrlPkg::ownerData)
        else begin
            errorCount++;
            $display("Fail dataWins expected %b actual %b", memCtrlPkg::ownerData,
                $sampled(owner));
        end

    dataFirst: assert property (@(posedge clk) disable iff (rst)
        fetchDone |-> !simulPending)
        else begin
            errorCount++;
            $display("fetch finished before the data request it raced with");
        end

    // two stalled cycles in a row inside a transfer must look the same
    stallHolds: assert property (@(posedge clk) disable iff (rst)
        !active && owner != memCtrlPkg::ownerNone |=>
            active || (owner == $past(owner) && memAddr == $past(memAddr)))
        else begin
            errorCount++;
            $display("Fail stallHolds expected %h actual %h", $past({owner, memAddr}),
                $sampled({owner, memAddr}));
        end

    function automatic logic [7:0] fillByte(input int idx);
        logic [7:0] lo;
        lo = 8'(idx);
        return (lo * 8'd37 + 8'd11) ^ {lo[2:0], lo[7:3]};
    endfunction

    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic logic [2:0] pickLen(input logic [31:0] r);
        case (r % 3)
            0: return 3'd1;
            1: return 3'd2;
            default: return 3'd4;
        endcase
    endfunction

    // little-endian, zero above len
    function automatic logic [31:0] refWord(input logic [31:0] addr, input int len);
        logic [31:0] w;
        w = '0;
        for (int k = 0; k < len; k++) begin
            w[k*8 +: 8] = refMem[8'(addr + 32'(k))];
        end
        return w;
    endfunction

    task automatic waitDone(input logic forFetch, input int stallMode);
        int   n;
        logic seen;
        n = 0;
        seen = 1'b0;
        while (!seen && n < timeoutCycles) begin
            @(negedge clk);
            n++;
            ready  = !(stallMode == 1 && n >= 2 && n <= 4);
            ioFull = (stallMode == 2 && n >= 2 && n <= 4);
            seen   = forFetch ? fetchDone : dataDone;
        end
        ready  = 1'b1;
        ioFull = 1'b0;
        if (!seen) begin
            timeoutCount++;
            $display("no done pulse from the %s side within %0d cycles",
                forFetch ? "fetch" : "data", timeoutCycles);
        end
    endtask

    task automatic issueFetch(input logic [31:0] addr, input int stallMode);
        @(negedge clk);
        expInst   = refWord(addr, 4);
        fetchAddr = addr;
        fetchEn   = 1'b1;
        waitDone(1'b1, stallMode);
        fetchEn = 1'b0;
    endtask

    task automatic accessData(input logic store, input logic [31:0] addr,
                              input logic [2:0] len, input logic [31:0] wdata,
                              input int stallMode);
        @(negedge clk);
        expStore   = store;
        expData    = refWord(addr, int'(len));
        expDataLat = store ? int'(len) : int'(len) + 1;
        dataAddr   = addr;
        dataLen    = len;
        dataWrite  = wdata;
        dataStore  = store;
        dataEn     = 1'b1;
        if (store) begin
            for (int k = 0; k < int'(len); k++) begin
                refMem[8'(addr + 32'(k))] = wdata[k*8 +: 8];
            end
        end
        waitDone(1'b0, stallMode);
        dataEn = 1'b0;
    endtask

    task automatic raceRequests(input logic [31:0] fAddr, input logic [31:0] dAddr,
                                input logic [2:0] len);
        @(negedge clk);
        expInst      = refWord(fAddr, 4);
        expStore     = 1'b0;
        expData      = refWord(dAddr, int'(len));
        expDataLat   = int'(len) + 1;
        fetchAddr    = fAddr;
        dataAddr     = dAddr;
        dataLen      = len;
        dataStore    = 1'b0;
        simulPending = 1'b1;
        fetchEn      = 1'b1;
        dataEn       = 1'b1;
        waitDone(1'b0, 0);
        dataEn       = 1'b0;
        simulPending = 1'b0;
        waitDone(1'b1, 0);
        fetchEn = 1'b0;
    endtask

    task automatic finishRun();
        $display("errors: %0d failed checks, %0d timeouts", errorCount, timeoutCount);
        if (errorCount == 0 && timeoutCount == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    endtask

    initial begin
        logic [31:0] a;
        logic [31:0] w;
        logic [2:0]  len;
        int          n;
        ready        = 1'b1;
        ioFull       = 1'b0;
        fetchEn      = 1'b0;
        fetchAddr    = '0;
        dataEn       = 1'b0;
        dataStore    = 1'b0;
        dataLen      = 3'd4;
        dataWrite    = '0;
        dataAddr     = '0;
        idlePhase    = 1'b0;
        simulPending = 1'b0;
        expStore     = 1'b0;
        expInst      = '0;
        expData      = '0;
        expDataLat   = 0;
        errorCount   = 0;
        timeoutCount = 0;
        lcgState     = 32'h3104;
        for (int i = 0; i < refDepth; i++) begin
            refMem[i] = fillByte(i);
        end

        n = 0;
        while (rst && n < timeoutCycles) begin
            @(negedge clk);
            n++;
        end
        if (rst) begin
            timeoutCount++;
            $display("reset never released");
        end

        idlePhase = 1'b1;
        repeat (6) @(negedge clk);
        idlePhase = 1'b0;

        for (int i = 0; i < 8; i++) begin
            issueFetch(nextRand(), 0);
        end

        for (int i = 0; i < 12; i++) begin
            a = nextRand();
            accessData(1'b0, a, pickLen(nextRand()), '0, 0);
        end

        // store, read back the same length, then the full word around it
        for (int i = 0; i < 10; i++) begin
            a   = nextRand();
            len = pickLen(nextRand());
            w   = nextRand();
            accessData(1'b1, a, len, w, 0);
            accessData(1'b0, a, len, '0, 0);
            accessData(1'b0, a, 3'd4, '0, 0);
        end

        for (int i = 0; i < 3; i++) begin
            a = nextRand();
            raceRequests(nextRand(), a, pickLen(nextRand()));
        end

        // stalls in the middle of transfers
        for (int i = 0; i < 4; i++) begin
            issueFetch(nextRand(), 1 + (i % 2));
            a = nextRand();
            accessData(1'b0, a, pickLen(nextRand()), '0, 2 - (i % 2));
            a = nextRand();
            w = nextRand();
            accessData(1'b1, a, 3'd4, w, 1 + (i % 2));
            accessData(1'b0, a, 3'd4, '0, 0);
        end

        repeat (3) @(negedge clk);
        finishRun();
    end

endmodule

`default_nettype wire

// File: vlog.f
src/memCtrlPkg.sv
src/memArbiter.sv
src/byteSequencer.sv
src/responseAssembler.sv
src/memCtrl.sv
tb/clockGen.sv
tb/ramModel.sv
tb/tbMemCtrl.sv

// File: run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wall \
    --top-module tbMemCtrl -f vlog.f -o simMemCtrl

out=$(./obj_dir/simMemCtrl)
echo "$out"

if grep -q "Test passed" <<< "$out"; then
    exit 0
else
    exit 1
fi
